// ==== build.f ====
hdl/fe_pkg.sv
hdl/cal_cfg_if.sv
hdl/fe_apb_regs.sv
hdl/adc_capture.sv
hdl/linear_cal.sv
hdl/dac_output.sv
hdl/pitaya_fe_top.sv
verif/fe_assert.sv
verif/fe_tb.sv

// ==== verif/fe_tb.sv ====
// front end testbench
// directed tests over APB, both datapaths and the digital loopback
// expected values come from the converter and calibration rules
// inputs change 1 unit after the rising edge, outputs read at the falling edge

module fe_tb;

  localparam int unsigned NUM_CH  = 2;
  // bound for every wait loop, in cycles
  localparam int          TIMEOUT = 100;
  // sample range
  localparam int          SMP_MAX = (1 << (fe_pkg::SMP_W - 1)) - 1;
  localparam int          SMP_MIN = -(1 << (fe_pkg::SMP_W - 1));

  logic                         adc_clk;
  logic                         top_rst;
  logic                         psel_i;
  logic                         penable_i;
  logic                         pwrite_i;
  fe_pkg::addr_t                paddr_i;
  fe_pkg::data_t                pwdata_i;
  fe_pkg::data_t                prdata_o;
  logic                         pready_o;
  logic                         pslverr_o;
  fe_pkg::raw_t    [NUM_CH-1:0] adc_dat_i;
  logic                         dac_vld_i;
  fe_pkg::sample_t [NUM_CH-1:0] dac_smp_i;
  logic                         osc_vld_o;
  fe_pkg::sample_t [NUM_CH-1:0] osc_dat_o;
  fe_pkg::raw_t                 dac_dat_o;
  logic                         dac_sel_o;

  // result bookkeeping
  int unsigned checks;
  int unsigned value_errs;
  int unsigned other_errs;
  int unsigned assert_errs;
  logic [31:0] lfsr_state;

  pitaya_fe_top #(.NUM_CH (NUM_CH)) i_pitaya_fe_top (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .adc_dat_i (adc_dat_i),
    .dac_vld_i (dac_vld_i),
    .dac_smp_i (dac_smp_i),
    .osc_vld_o (osc_vld_o),
    .osc_dat_o (osc_dat_o),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

  // 4 unit period
  initial adc_clk = 1'b0;
  always #2 adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////
  // models and random numbers
  ////////////////////////////////////////////////////////////

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // y = sat(floor(x * m / 2^shift) + s)
  function automatic fe_pkg::sample_t cal_model(input fe_pkg::sample_t x,
                                                input fe_pkg::mul_t m,
                                                input fe_pkg::sum_t s);
    longint p;
    p = longint'(x) * longint'(m);
    p = (p >>> fe_pkg::CAL_SHIFT) + longint'(s);
    if (p > SMP_MAX) begin
      p = SMP_MAX;
    end else if (p < SMP_MIN) begin
      p = SMP_MIN;
    end
    return fe_pkg::sample_t'(p);
  endfunction

  // inverted offset binary, complement of (x + half scale)
  function automatic fe_pkg::raw_t encode_sample(input fe_pkg::sample_t x);
    int v;
    v = int'(x) + (1 << (fe_pkg::SMP_W - 1));
    return fe_pkg::raw_t'(~v);
  endfunction

  function automatic fe_pkg::sample_t decode_adc(input fe_pkg::raw_t c);
    fe_pkg::raw_t inv;
    inv = ~c;
    return fe_pkg::sample_t'(int'(inv) - (1 << (fe_pkg::SMP_W - 1)));
  endfunction

  function automatic fe_pkg::cal_word_u make_cal(input fe_pkg::mul_t m,
                                                 input fe_pkg::sum_t s);
    fe_pkg::cal_word_u w;
    w.raw     = '0;
    w.cal.mul = m;
    w.cal.sum = s;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_sample(input string name, input fe_pkg::sample_t exp,
                              input fe_pkg::sample_t act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_raw(input string name, input fe_pkg::raw_t exp,
                           input fe_pkg::raw_t act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input fe_pkg::cal_word_u exp,
                            input fe_pkg::cal_word_u act);
    checks++;
    if (act.raw !== exp.raw) begin
      value_errs++;
      $display("FAIL %s: expected %h, actual %h", name, exp.raw, act.raw);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and stream drivers
  ////////////////////////////////////////////////////////////

  // setup cycle, then access until pready
  task automatic apb_access(input fe_pkg::addr_t addr, input logic wr,
                            input fe_pkg::data_t wdata,
                            output fe_pkg::data_t rdata, output logic err);
    int n;
    @(posedge adc_clk);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge adc_clk);
    #1;
    penable_i = 1'b1;
    n = 0;
    @(negedge adc_clk);
    while (pready_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge adc_clk);
      n++;
    end
    if (pready_o !== 1'b1) begin
      other_errs++;
      $display("APB access to %h never got pready", addr);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge adc_clk);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input fe_pkg::addr_t addr, input fe_pkg::data_t wdata,
                           output logic err);
    fe_pkg::data_t unused;
    apb_access(addr, 1'b1, wdata, unused, err);
  endtask

  task automatic apb_read(input fe_pkg::addr_t addr, output fe_pkg::data_t rdata,
                          output logic err);
    apb_access(addr, 1'b0, '0, rdata, err);
  endtask

  task automatic set_cal(input fe_pkg::addr_t base, input int ch,
                         input fe_pkg::mul_t m, input fe_pkg::sum_t s);
    fe_pkg::cal_word_u w;
    logic              err;
    w = make_cal(m, s);
    apb_write(fe_pkg::addr_t'(base + 4 * ch), w.raw, err);
    check_bit("cal write pslverr", 1'b0, err);
  endtask

  // unity gain, no offset, loopback off
  task automatic restore_defaults();
    logic err;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      set_cal(fe_pkg::REG_ADC_CAL, ch, 16'sh4000, '0);
      set_cal(fe_pkg::REG_DAC_CAL, ch, 16'sh4000, '0);
    end
    apb_write(fe_pkg::REG_CTRL, '0, err);
    check_bit("ctrl write pslverr", 1'b0, err);
  endtask

  task automatic drive_adc(input fe_pkg::raw_t c0, input fe_pkg::raw_t c1);
    @(posedge adc_clk);
    #1;
    adc_dat_i[0] = c0;
    adc_dat_i[1] = c1;
  endtask

  task automatic drive_dac(input fe_pkg::sample_t x0, input fe_pkg::sample_t x1);
    @(posedge adc_clk);
    #1;
    dac_vld_i    = 1'b1;
    dac_smp_i[0] = x0;
    dac_smp_i[1] = x1;
  endtask

  // inputs held steady while the pipelines fill
  task automatic settle(input int n);
    repeat (n) @(posedge adc_clk);
    @(negedge adc_clk);
  endtask

  task automatic wait_osc_valid();
    int n;
    n = 0;
    @(negedge adc_clk);
    while (osc_vld_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge adc_clk);
      n++;
    end
    if (osc_vld_o !== 1'b1) begin
      other_errs++;
      $display("osc_vld_o did not rise after reset");
    end
  endtask

  // two consecutive cycles cover both select phases
  task automatic check_dac_phases(input string name, input fe_pkg::raw_t code0,
                                  input fe_pkg::raw_t code1);
    repeat (2) begin
      @(negedge adc_clk);
      if (dac_sel_o) begin
        check_raw({name, " ch0"}, code0, dac_dat_o);
      end else begin
        check_raw({name, " ch1"}, code1, dac_dat_o);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    fe_pkg::data_t rd;
    logic          err;
    // 16 rising edges in reset, outputs checked before the last
    repeat (15) @(posedge adc_clk);
    @(negedge adc_clk);
    check_raw("reset dac_dat_o", 14'h2000, dac_dat_o);
    check_bit("reset dac_sel_o", 1'b0, dac_sel_o);
    check_bit("reset osc_vld_o", 1'b0, osc_vld_o);
    @(posedge adc_clk);
    #1;
    top_rst = 1'b0;
    apb_read(fe_pkg::REG_CTRL, rd, err);
    check_word("reset ctrl", '0, rd);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      apb_read(fe_pkg::addr_t'(fe_pkg::REG_ADC_CAL + 4 * ch), rd, err);
      check_word("reset adc cal", make_cal(16'sh4000, '0), rd);
      apb_read(fe_pkg::addr_t'(fe_pkg::REG_DAC_CAL + 4 * ch), rd, err);
      check_word("reset dac cal", make_cal(16'sh4000, '0), rd);
    end
    // generator idles at -1, which is the midscale code
    settle(4);
    check_dac_phases("reset midscale", 14'h2000, 14'h2000);
  endtask

  task automatic test_regs();
    fe_pkg::addr_t addr [5];
    fe_pkg::data_t mask [5];
    fe_pkg::addr_t bad  [3];
    fe_pkg::data_t wd;
    fe_pkg::data_t rd;
    logic          err;
    addr[0] = fe_pkg::REG_CTRL;
    mask[0] = 32'h0000_0001;
    // cal words drop reserved bits 15:14
    for (int ch = 0; ch < NUM_CH; ch++) begin
      addr[1 + ch] = fe_pkg::addr_t'(fe_pkg::REG_ADC_CAL + 4 * ch);
      addr[3 + ch] = fe_pkg::addr_t'(fe_pkg::REG_DAC_CAL + 4 * ch);
      mask[1 + ch] = 32'hffff_3fff;
      mask[3 + ch] = 32'hffff_3fff;
    end
    for (int i = 0; i < 5; i++) begin
      wd = rand_bits(32);
      apb_write(addr[i], wd, err);
      check_bit("regs write pslverr", 1'b0, err);
      apb_read(addr[i], rd, err);
      check_bit("regs read pslverr", 1'b0, err);
      check_word("regs readback", wd & mask[i], rd);
    end
    // holes in the map
    bad[0] = 8'h04;
    bad[1] = 8'h18;
    bad[2] = 8'hfc;
    foreach (bad[i]) begin
      apb_write(bad[i], rand_bits(32), err);
      check_bit("unmapped write pslverr", 1'b1, err);
      apb_read(bad[i], rd, err);
      check_bit("unmapped read pslverr", 1'b1, err);
      check_word("unmapped read data", '0, rd);
    end
    restore_defaults();
  endtask

  task automatic test_adc_path();
    fe_pkg::raw_t c0;
    fe_pkg::raw_t c1;
    wait_osc_valid();
    for (int i = 0; i < 7; i++) begin
      // full scale codes first, then random words
      c0 = (i == 0) ? 14'h0000 : fe_pkg::raw_t'(rand_bits(14));
      c1 = (i == 0) ? 14'h3fff : fe_pkg::raw_t'(rand_bits(14));
      drive_adc(c0, c1);
      settle(4);
      check_bit("adc path valid", 1'b1, osc_vld_o);
      check_sample("adc path ch0", decode_adc(c0), osc_dat_o[0]);
      check_sample("adc path ch1", decode_adc(c1), osc_dat_o[1]);
    end
  endtask

  task automatic adc_cal_case(input string name,
                              input fe_pkg::mul_t m0, input fe_pkg::sum_t s0,
                              input fe_pkg::sample_t x0,
                              input fe_pkg::mul_t m1, input fe_pkg::sum_t s1,
                              input fe_pkg::sample_t x1);
    set_cal(fe_pkg::REG_ADC_CAL, 0, m0, s0);
    set_cal(fe_pkg::REG_ADC_CAL, 1, m1, s1);
    drive_adc(encode_sample(x0), encode_sample(x1));
    settle(4);
    check_sample({name, " ch0"}, cal_model(x0, m0, s0), osc_dat_o[0]);
    check_sample({name, " ch1"}, cal_model(x1, m1, s1), osc_dat_o[1]);
  endtask

  task automatic test_adc_cal();
    adc_cal_case("adc cal scale", 16'sh2000, 100, fe_pkg::sample_t'(rand_bits(14)),
                 -16384, -5, fe_pkg::sample_t'(rand_bits(14)));
    // gain near 2 pushes both rails
    adc_cal_case("adc cal gain sat", 16'sh7fff, 0, 6000, 16'sh7fff, 0, -6000);
    adc_cal_case("adc cal offset sat", 16'sh4000, 4000, 5000, 16'sh4000, -4000, -5000);
    adc_cal_case("adc cal random",
                 fe_pkg::mul_t'(rand_bits(16)), fe_pkg::sum_t'(rand_bits(14)),
                 fe_pkg::sample_t'(rand_bits(14)),
                 fe_pkg::mul_t'(rand_bits(16)), fe_pkg::sum_t'(rand_bits(14)),
                 fe_pkg::sample_t'(rand_bits(14)));
    restore_defaults();
  endtask

  task automatic dac_cal_case(input string name,
                              input fe_pkg::mul_t m0, input fe_pkg::sum_t s0,
                              input fe_pkg::sample_t x0,
                              input fe_pkg::mul_t m1, input fe_pkg::sum_t s1,
                              input fe_pkg::sample_t x1);
    set_cal(fe_pkg::REG_DAC_CAL, 0, m0, s0);
    set_cal(fe_pkg::REG_DAC_CAL, 1, m1, s1);
    drive_dac(x0, x1);
    settle(5);
    check_dac_phases(name, encode_sample(cal_model(x0, m0, s0)),
                     encode_sample(cal_model(x1, m1, s1)));
  endtask

  task automatic test_dac_path();
    dac_cal_case("dac cal scale", 16'sh3000, -200, fe_pkg::sample_t'(rand_bits(14)),
                 16'sh5000, 300, fe_pkg::sample_t'(rand_bits(14)));
    dac_cal_case("dac cal sat", 16'sh7fff, 0, 7000, 16'sh7fff, 0, -7000);
    dac_cal_case("dac cal random",
                 fe_pkg::mul_t'(rand_bits(16)), fe_pkg::sum_t'(rand_bits(14)),
                 fe_pkg::sample_t'(rand_bits(14)),
                 fe_pkg::mul_t'(rand_bits(16)), fe_pkg::sum_t'(rand_bits(14)),
                 fe_pkg::sample_t'(rand_bits(14)));
    restore_defaults();
  endtask

  task automatic test_loopback();
    fe_pkg::mul_t    dac_m [2];
    fe_pkg::sum_t    dac_s [2];
    fe_pkg::mul_t    adc_m [2];
    fe_pkg::sum_t    adc_s [2];
    fe_pkg::sample_t d     [2];
    fe_pkg::sample_t e     [2];
    logic            err;
    dac_m[0] = 16'sh4800;
    dac_s[0] = 50;
    dac_m[1] = 16'sh3800;
    dac_s[1] = -70;
    adc_m[0] = 16'sh2000;
    adc_s[0] = 10;
    adc_m[1] = fe_pkg::mul_t'(rand_bits(16));
    adc_s[1] = fe_pkg::sum_t'(rand_bits(14));
    for (int ch = 0; ch < NUM_CH; ch++) begin
      set_cal(fe_pkg::REG_DAC_CAL, ch, dac_m[ch], dac_s[ch]);
      set_cal(fe_pkg::REG_ADC_CAL, ch, adc_m[ch], adc_s[ch]);
      d[ch] = fe_pkg::sample_t'(rand_bits(14));
      // DAC calibration then ADC calibration
      e[ch] = cal_model(cal_model(d[ch], dac_m[ch], dac_s[ch]), adc_m[ch], adc_s[ch]);
    end
    apb_write(fe_pkg::REG_CTRL, 32'h1, err);
    check_bit("loopback ctrl pslverr", 1'b0, err);
    drive_dac(d[0], d[1]);
    // ADC pins must not matter
    repeat (2) begin
      drive_adc(fe_pkg::raw_t'(rand_bits(14)), fe_pkg::raw_t'(rand_bits(14)));
      settle(8);
      check_sample("loopback ch0", e[0], osc_dat_o[0]);
      check_sample("loopback ch1", e[1], osc_dat_o[1]);
    end
    restore_defaults();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr_state  = 32'h2f6f_8920;
    checks      = 0;
    value_errs  = 0;
    other_errs  = 0;
    assert_errs = 0;
    top_rst     = 1'b1;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    adc_dat_i   = '0;
    dac_vld_i   = 1'b1;
    dac_smp_i   = '1;
    test_reset();
    test_regs();
    test_adc_path();
    test_adc_cal();
    test_dac_path();
    test_loopback();
    // protocol assertions in the bound checker
    assert_errs = i_pitaya_fe_top.i_fe_assert.fail_cnt;
    $display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
             checks, value_errs, other_errs, assert_errs);
    if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verif/fe_assert.sv ====
// front end protocol checks
// APB response timing, acquisition valid in reset and the
// DAC channel select, bound into the top level

module fe_assert (
  input logic adc_clk,
  input logic top_rst,
  input logic psel_i,
  input logic penable_i,
  input logic pready_o,
  input logic pslverr_o,
  input logic osc_vld_o,
  input logic dac_sel_o
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // pready only in the access phase of a selected transfer
  a_pready_access : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    pready_o |-> (psel_i && penable_i)
  ) else begin
    fail_cnt++;
    $error("pready high outside an APB access phase");
  end

  // error response only together with pready
  a_pslverr_ready : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    pslverr_o |-> pready_o
  ) else begin
    fail_cnt++;
    $error("pslverr high without pready");
  end

  // no acquisition data while in reset
  a_osc_vld_reset : assert property (
    @(posedge adc_clk)
    top_rst |-> !osc_vld_o
  ) else begin
    fail_cnt++;
    $error("osc_vld_o high during reset");
  end

  // interleave select flips on every edge out of reset
  a_dac_sel_toggle : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    1'b1 |=> (dac_sel_o != $past(dac_sel_o))
  ) else begin
    fail_cnt++;
    $error("dac_sel_o did not toggle");
  end

endmodule

bind pitaya_fe_top fe_assert i_fe_assert (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_o  (pready_o),
  .pslverr_o (pslverr_o),
  .osc_vld_o (osc_vld_o),
  .dac_sel_o (dac_sel_o)
);

// ==== hdl/pitaya_fe_top.sv ====
// analog front end top level
// two ADC and two DAC channels with gain/offset calibration,
// digital loopback from DAC to ADC, and an APB register block
// everything on adc_clk, asynchronous active high top_rst

module pitaya_fe_top #(
  parameter int unsigned NUM_CH = 2
)(
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // APB slave
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  fe_pkg::addr_t                paddr_i,
  input  fe_pkg::data_t                pwdata_i,
  output fe_pkg::data_t                prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // ADC pins
  input  fe_pkg::raw_t    [NUM_CH-1:0] adc_dat_i,
  // generator stream
  input  logic                         dac_vld_i,
  input  fe_pkg::sample_t [NUM_CH-1:0] dac_smp_i,
  // acquisition stream
  output logic                         osc_vld_o,
  output fe_pkg::sample_t [NUM_CH-1:0] osc_dat_o,
  // DAC pins
  output fe_pkg::raw_t                 dac_dat_o,
  output logic                         dac_sel_o
);

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // capture -> ADC calibration
  logic                         cap_vld;
  fe_pkg::sample_t [NUM_CH-1:0] cap_smp;
  // DAC calibration -> output stage and loopback
  logic                         dcl_vld;
  fe_pkg::sample_t [NUM_CH-1:0] dcl_smp;

  cal_cfg_if #(.NUM_CH (NUM_CH)) cfg ();

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  fe_apb_regs #(.NUM_CH (NUM_CH)) regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg       (cfg)
  );

  ////////////////////////////////////////////////////////////
  // ADC path
  ////////////////////////////////////////////////////////////

  adc_capture #(.NUM_CH (NUM_CH)) capture (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .cfg        (cfg),
    .adc_dat_i  (adc_dat_i),
    // loopback taken at the DAC output stage input
    .loop_smp_i (dcl_smp),
    .vld_o      (cap_vld),
    .smp_o      (cap_smp)
  );

  linear_cal #(.NUM_CH (NUM_CH)) adc_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .vld_i   (cap_vld),
    .smp_i   (cap_smp),
    .mul_i   (cfg.adc_mul),
    .sum_i   (cfg.adc_sum),
    .vld_o   (osc_vld_o),
    .smp_o   (osc_dat_o)
  );

  ////////////////////////////////////////////////////////////
  // DAC path
  ////////////////////////////////////////////////////////////

  linear_cal #(.NUM_CH (NUM_CH)) dac_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .vld_i   (dac_vld_i),
    .smp_i   (dac_smp_i),
    .mul_i   (cfg.dac_mul),
    .sum_i   (cfg.dac_sum),
    .vld_o   (dcl_vld),
    .smp_o   (dcl_smp)
  );

  dac_output #(.NUM_CH (NUM_CH)) dac_out (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .vld_i     (dcl_vld),
    .smp_i     (dcl_smp),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

endmodule

// ==== hdl/dac_output.sv ====
// DAC output stage
// holds the last valid sample pair and interleaves the channels
// onto the shared DAC bus, select toggling every cycle
// select high carries channel 0, midscale while in reset

module dac_output #(
  parameter int unsigned NUM_CH = 2
)(
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // calibrated stream in
  input  logic                         vld_i,
  input  fe_pkg::sample_t [NUM_CH-1:0] smp_i,
  // DAC pins
  output fe_pkg::raw_t                 dac_dat_o,
  output logic                         dac_sel_o
);

  // pair held between valid samples
  fe_pkg::sample_t [NUM_CH-1:0] hold_q;
  // new pair when valid, else the held one
  fe_pkg::sample_t [NUM_CH-1:0] pick;

  assign pick = vld_i ? smp_i : hold_q;

  always_ff @(posedge adc_clk) begin
    if (vld_i) begin
      hold_q <= smp_i;
    end
  end

  // select and data move together
  // next select is ~dac_sel_o, so the channel index is dac_sel_o
  // sel low now -> sel high next -> channel 0
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= fe_pkg::DAC_MID;
    end else begin
      dac_sel_o <= ~dac_sel_o;
      dac_dat_o <= fe_pkg::smp_to_code(pick[dac_sel_o]);
    end
  end

endmodule

// ==== hdl/linear_cal.sv ====
// linear calibration, y = sat((x * mul) >>> CAL_SHIFT + sum)
// two register stages: product, then shift/offset/saturate
// same block serves the ADC and the DAC path

module linear_cal #(
  parameter int unsigned NUM_CH = 2
)(
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // stream in
  input  logic                         vld_i,
  input  fe_pkg::sample_t [NUM_CH-1:0] smp_i,
  // per channel gain/offset
  input  fe_pkg::mul_t    [NUM_CH-1:0] mul_i,
  input  fe_pkg::sum_t    [NUM_CH-1:0] sum_i,
  // stream out
  output logic                         vld_o,
  output fe_pkg::sample_t [NUM_CH-1:0] smp_o
);

  // full product, shifted product, and one guard bit for the offset
  localparam int unsigned PRD_W = fe_pkg::SMP_W + fe_pkg::MUL_W;
  localparam int unsigned SHF_W = PRD_W - fe_pkg::CAL_SHIFT;
  localparam int unsigned ACC_W = SHF_W + 1;
  localparam int unsigned SW    = fe_pkg::SMP_W;

  logic                    vld_q;
  logic signed [PRD_W-1:0] prd_q [NUM_CH];
  logic signed [SHF_W-1:0] shf   [NUM_CH];
  logic signed [ACC_W-1:0] acc   [NUM_CH];
  fe_pkg::sample_t         sat   [NUM_CH];

  ////////////////////////////////////////////////////////////
  // stage 1 multiply
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      prd_q[i] <= $signed(smp_i[i]) * $signed(mul_i[i]);
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2 shift, offset, saturate
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      shf[i] = SHF_W'(prd_q[i] >>> fe_pkg::CAL_SHIFT);
      // sign extended add, cannot overflow ACC_W
      acc[i] = {shf[i][SHF_W-1], shf[i]} + ACC_W'($signed(sum_i[i]));
      // in range when all bits above the sample msb match it
      if (&acc[i][ACC_W-1:SW-1] || ~|acc[i][ACC_W-1:SW-1]) begin
        sat[i] = acc[i][SW-1:0];
      end else begin
        sat[i] = {acc[i][ACC_W-1], {(SW-1){~acc[i][ACC_W-1]}}};
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      smp_o[i] <= sat[i];
    end
  end

  // valid follows the data through both stages
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_q <= 1'b0;
      vld_o <= 1'b0;
    end else begin
      vld_q <= vld_i;
      vld_o <= vld_q;
    end
  end

endmodule

// ==== hdl/adc_capture.sv ====
// ADC capture stage
// registers the raw converter words, turns inverted offset binary
// into two's complement and optionally swaps in the DAC loopback

module adc_capture #(
  parameter int unsigned NUM_CH = 2
)(
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // loopback enable
  cal_cfg_if.adc                       cfg,
  // converter pins
  input  fe_pkg::raw_t    [NUM_CH-1:0] adc_dat_i,
  // calibrated DAC samples
  input  fe_pkg::sample_t [NUM_CH-1:0] loop_smp_i,
  // stream out
  output logic                         vld_o,
  output fe_pkg::sample_t [NUM_CH-1:0] smp_o
);

  // input register, ideally packed into the IO block
  fe_pkg::raw_t raw_q [NUM_CH];

  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      raw_q[i] <= adc_dat_i[i];
    end
  end

  // ADC runs every cycle
  // so valid is just reset release, one flop late
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= 1'b1;
    end
  end

  // code conversion and loopback mux
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (cfg.digital_loop) begin
        smp_o[i] = loop_smp_i[i];
      end else begin
        smp_o[i] = fe_pkg::code_to_smp(raw_q[i]);
      end
    end
  end

endmodule

// ==== hdl/fe_apb_regs.sv ====
// front end register block
// APB slave, zero wait states, holding the control register
// (digital loopback) and one calibration word per channel and path
// unmapped offsets answer with pslverr, reads of them return zero

module fe_apb_regs #(
  parameter int unsigned NUM_CH = 2
)(
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // APB slave
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  fe_pkg::addr_t        paddr_i,
  input  fe_pkg::data_t        pwdata_i,
  output fe_pkg::data_t        prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  // settings towards the datapath
  cal_cfg_if.regs              cfg
);

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  logic              access;
  logic              wr_en;
  logic              ctrl_hit;
  logic [NUM_CH-1:0] adc_hit;
  logic [NUM_CH-1:0] dac_hit;
  logic              map_hit;

  // register storage
  logic              loop_q;
  fe_pkg::cal_word_u adc_cal_q [NUM_CH];
  fe_pkg::cal_word_u dac_cal_q [NUM_CH];

  // access phase of a selected transfer
  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  assign ctrl_hit = (paddr_i == fe_pkg::REG_CTRL);

  // channel i lives at base + 4*i
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      adc_hit[i] = (paddr_i == fe_pkg::addr_t'(fe_pkg::REG_ADC_CAL + 4*i));
      dac_hit[i] = (paddr_i == fe_pkg::addr_t'(fe_pkg::REG_DAC_CAL + 4*i));
    end
  end

  assign map_hit = ctrl_hit | (|adc_hit) | (|dac_hit);

  ////////////////////////////////////////////////////////////
  // bus response
  ////////////////////////////////////////////////////////////

  // no wait states
  assign pready_o  = access;
  assign pslverr_o = access & ~map_hit;

  // read mux, zero when nothing matches
  always_comb begin
    prdata_o = '0;
    if (ctrl_hit) begin
      prdata_o[fe_pkg::CTRL_LOOP_BIT] = loop_q;
    end
    for (int i = 0; i < NUM_CH; i++) begin
      if (adc_hit[i]) begin
        prdata_o = adc_cal_q[i].raw;
      end
      if (dac_hit[i]) begin
        prdata_o = dac_cal_q[i].raw;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  // writes land on the access edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop_q <= 1'b0;
      for (int i = 0; i < NUM_CH; i++) begin
        adc_cal_q[i].raw <= fe_pkg::CAL_RST;
        dac_cal_q[i].raw <= fe_pkg::CAL_RST;
      end
    end else if (wr_en) begin
      if (ctrl_hit) begin
        loop_q <= pwdata_i[fe_pkg::CTRL_LOOP_BIT];
      end
      // reserved bits dropped on the way in
      for (int i = 0; i < NUM_CH; i++) begin
        if (adc_hit[i]) begin
          adc_cal_q[i].raw <= pwdata_i & fe_pkg::CAL_MASK;
        end
        if (dac_hit[i]) begin
          dac_cal_q[i].raw <= pwdata_i & fe_pkg::CAL_MASK;
        end
      end
    end
  end

  // datapath sees the field view
  assign cfg.digital_loop = loop_q;

  for (genvar i = 0; i < NUM_CH; i++) begin : g_cfg
    assign cfg.adc_mul[i] = adc_cal_q[i].cal.mul;
    assign cfg.adc_sum[i] = adc_cal_q[i].cal.sum;
    assign cfg.dac_mul[i] = dac_cal_q[i].cal.mul;
    assign cfg.dac_sum[i] = dac_cal_q[i].cal.sum;
  end : g_cfg

endmodule

// ==== hdl/cal_cfg_if.sv ====
// calibration and loopback settings
// carries gain/offset per channel for both paths and the
// digital loopback enable from the register block to the datapath

interface cal_cfg_if #(
  parameter int unsigned NUM_CH = 2
);

  // ADC side gain/offset
  fe_pkg::mul_t [NUM_CH-1:0] adc_mul;
  fe_pkg::sum_t [NUM_CH-1:0] adc_sum;
  // DAC side gain/offset
  fe_pkg::mul_t [NUM_CH-1:0] dac_mul;
  fe_pkg::sum_t [NUM_CH-1:0] dac_sum;
  // DAC stream fed back into ADC path
  logic                      digital_loop;

  // register block owns everything
  modport regs (output adc_mul, adc_sum, dac_mul, dac_sum, digital_loop);
  // acquisition side
  modport adc  (input adc_mul, adc_sum, digital_loop);
  // generation side
  modport dac  (input dac_mul, dac_sum);

endinterface

// ==== hdl/fe_pkg.sv ====
// analog front end package
// sample and gain widths, stream sample types, the calibration
// register word and the APB register map shared by all blocks

package fe_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // ADC/DAC sample width
  localparam int unsigned SMP_W     = 14;
  // gain width and its binary point
  localparam int unsigned MUL_W     = 16;
  localparam int unsigned CAL_SHIFT = 14;
  // register bus
  localparam int unsigned APB_AW    = 8;
  localparam int unsigned APB_DW    = 32;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic signed [SMP_W-1:0] sample_t;
  // offset binary word on the converter pins
  typedef logic        [SMP_W-1:0] raw_t;
  typedef logic signed [MUL_W-1:0] mul_t;
  typedef logic signed [SMP_W-1:0] sum_t;

  typedef logic [APB_AW-1:0] addr_t;
  typedef logic [APB_DW-1:0] data_t;

  // datapath view of a calibration register
  typedef struct packed {
    mul_t       mul;
    logic [1:0] rsv;
    sum_t       sum;
  } cal_fields_t;

  // bus side sees raw, datapath side sees cal
  typedef union packed {
    data_t       raw;
    cal_fields_t cal;
  } cal_word_u;

  ////////////////////////////////////////////////////////////
  // constants and register map
  ////////////////////////////////////////////////////////////

  // 1.0 in the gain format
  localparam mul_t  MUL_UNITY = 16'h4000;
  // calibration word after reset: unity gain, no offset
  localparam data_t CAL_RST   = {MUL_UNITY, {(APB_DW-MUL_W){1'b0}}};
  // reserved bits 15:14 read back as zero
  localparam data_t CAL_MASK  = {{MUL_W{1'b1}}, 2'b00, {SMP_W{1'b1}}};
  // DAC code for zero output
  localparam raw_t  DAC_MID   = {1'b1, {(SMP_W-1){1'b0}}};

  localparam addr_t REG_CTRL    = 8'h00;
  localparam addr_t REG_ADC_CAL = 8'h10;
  localparam addr_t REG_DAC_CAL = 8'h20;
  // control register fields
  localparam int unsigned CTRL_LOOP_BIT = 0;

  // converter code <-> two's complement
  // msb kept, the rest inverted (negative slope)
  function automatic sample_t code_to_smp(raw_t code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

  function automatic raw_t smp_to_code(sample_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

endpackage
